// File: sim.f
+incdir+.
fetch_pkg.sv
l1i_cache.sv
apb_fetch_master.sv
fetch_ctrl.sv
ifu_top.sv
tb_apb_mem.sv
tb_ifu_top.sv

// File: Bender.yml
package:
  name: ifu_fetch

sources:
  - include_dirs:
      - .
    files:
      - fetch_pkg.sv
      - l1i_cache.sv
      - apb_fetch_master.sv
      - fetch_ctrl.sv
      - ifu_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_apb_mem.sv
      - tb_ifu_top.sv

// File: tb_ifu_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "fetch_settings.svh"

module tb_ifu_top;

  localparam int XFER_TOTAL  = 400;
  localparam int CYCLE_LIMIT = XFER_TOTAL * 40; // worst miss plus stall per transfer.

  logic        clk;
  logic        rst;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic        ready;
  logic        valid;
  logic [31:0] inst;
  logic [31:0] pc;
  logic        psel;
  logic        penable;
  logic [31:0] paddr;
  logic        pwrite;
  logic [31:0] prdata;
  logic        pready;
  logic [31:0] read_count;

  // model of 4 sets, 2-word lines.
  logic [31:0] ref_mem [256];
  logic [31:0] read_log [$];
  logic [26:0] model_tag [4];
  logic [3:0]  model_valid;
  logic [31:0] exp_pc;
  logic [31:0] last_count;
  logic        waiting;
  int          xfer_count;
  int          cycles;

  ifu_top ifu_top_i (
    .clk           (clk),
    .rst           (rst),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .ready_i       (ready),
    .valid_o       (valid),
    .inst_o        (inst),
    .pc_o          (pc),
    .psel_o        (psel),
    .penable_o     (penable),
    .paddr_o       (paddr),
    .pwrite_o      (pwrite),
    .prdata_i      (prdata),
    .pready_i      (pready)
  );

  tb_apb_mem apb_mem_i (
    .clk          (clk),
    .rst          (rst),
    .psel_i       (psel),
    .penable_i    (penable),
    .paddr_i      (paddr),
    .pwrite_i     (pwrite),
    .prdata_o     (prdata),
    .pready_o     (pready),
    .read_count_o (read_count)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] ref_word(input logic [31:0] addr);
    return ref_mem[addr[9:2]];
  endfunction

  // jal, jalr, branch, system and load hand the next pc to the back end.
  function automatic logic ends_sequence(input logic [31:0] w);
    case (w[6:0])
      7'b1101111, 7'b1100111, 7'b1100011, 7'b1110011, 7'b0000011: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] make_word();
    logic [31:0] w;
    int unsigned r;
    w = $urandom();
    r = $urandom_range(23, 0);
    case (r)
      0: w[6:0] = 7'b1101111;
      1: w[6:0] = 7'b1100111;
      2: w[6:0] = 7'b1100011;
      3: w[6:0] = 7'b1110011;
      4, 5: w[6:0] = 7'b0000011; // load.
      6: w = `INST_FENCE_I;
      default: w[6:0] = r[0] ? 7'b0010011 : 7'b0110011;
    endcase
    return w;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at the first error.");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_transfer();
    logic [1:0]  idx;
    logic [26:0] tag;
    logic [31:0] reads;
    idx   = exp_pc[4:3];
    tag   = exp_pc[31:5];
    reads = (model_valid[idx] && (model_tag[idx] == tag)) ? 32'd0 : 32'd2;
    check_value("pc_o", pc, exp_pc);
    check_value("inst_o", inst, ref_word(exp_pc));
    check_value("apb read count", read_count - last_count, reads);
    check_value("apb read log", read_log.size(), reads);
    foreach (read_log[i]) begin
      check_value("paddr_o", read_log[i], {exp_pc[31:3], 3'b000} + 32'(4 * i));
    end
    read_log.delete();
    last_count       = read_count;
    model_valid[idx] = 1'b1;
    model_tag[idx]   = tag;
    if (ref_word(exp_pc) == `INST_FENCE_I) begin
      model_valid = '0; // every line gone.
    end
    if (ends_sequence(ref_word(exp_pc))) begin
      waiting = 1'b1;
    end else begin
      exp_pc = exp_pc + 32'd4;
    end
    xfer_count++;
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      if (psel && penable && pready) begin
        check_value("pwrite_o", {31'b0, pwrite}, 32'h0);
        read_log.push_back(paddr);
      end
      if (waiting && valid) begin
        fail_run("valid_o rose while the stage was waiting for a redirect.");
      end else if (valid && ready) begin
        check_transfer();
      end else if (waiting && redirect) begin
        exp_pc  = redirect_pc;
        waiting = 1'b0;
      end
      if (xfer_count == XFER_TOTAL) begin
        $display("*** TEST PASSED ***");
        $finish;
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      fail_run($sformatf("timeout: %0d cycles passed with only %0d of %0d transfers seen.",
                         cycles, xfer_count, XFER_TOTAL));
    end
  end

  initial begin
    void'($urandom(59565));
    clk         = 1'b0;
    rst         = 1'b1;
    ready       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    waiting     = 1'b0;
    exp_pc      = `FETCH_PC_INIT;
    model_valid = '0;
    last_count  = '0;
    xfer_count  = 0;
    cycles      = 0;
    for (int k = 0; k < 256; k++) begin
      ref_mem[k]       = make_word();
      apb_mem_i.mem[k] = ref_mem[k];
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    forever begin
      @(negedge clk);
      ready    = ($urandom_range(3, 0) != 0);
      redirect = 1'b0;
      if (waiting && ($urandom_range(1, 0) == 1)) begin
        redirect    = 1'b1;
        redirect_pc = `FETCH_PC_INIT + ($urandom_range(255, 0) << 2); // stays in memory.
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_apb_mem.sv
`timescale 1ns/100ps
`default_nettype none
`include "fetch_settings.svh"

module tb_apb_mem (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      psel_i,
  input  wire                      penable_i,
  input  wire [`FETCH_ADDR_W-1:0]  paddr_i,
  input  wire                      pwrite_i,
  output logic [31:0]              prdata_o,
  output logic                     pready_o,
  output logic [31:0]              read_count_o
);

  logic [31:0] mem [256]; // loaded by the testbench.
  int unsigned wait_q;

  initial begin
    prdata_o = '0;
    pready_o = 1'b0;
    wait_q   = 0;
  end

  // wait states picked in setup, pready driven on the falling edge.
  always @(negedge clk) begin
    if (rst || !psel_i) begin
      pready_o <= 1'b0;
    end else if (!penable_i) begin
      wait_q   <= $urandom_range(3, 0);
      pready_o <= 1'b0;
      prdata_o <= mem[paddr_i[9:2]]; // 1 KiB window, wraps.
    end else if (wait_q == 0) begin
      pready_o <= 1'b1;
    end else begin
      wait_q <= wait_q - 1;
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      read_count_o <= '0;
    end else if (psel_i && penable_i && pready_o && !pwrite_i) begin
      read_count_o <= read_count_o + 1;
    end
  end

endmodule

`default_nettype wire

// File: ifu_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "fetch_settings.svh"

module ifu_top (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      redirect_i,
  input  wire [`FETCH_ADDR_W-1:0]  redirect_pc_i,
  input  wire                      ready_i,
  output logic                     valid_o,
  output logic [31:0]              inst_o,
  output logic [`FETCH_ADDR_W-1:0] pc_o,
  output logic                     psel_o,
  output logic                     penable_o,
  output logic [`FETCH_ADDR_W-1:0] paddr_o,
  output logic                     pwrite_o,
  input  wire [31:0]               prdata_i,
  input  wire                      pready_i
);

  logic [`FETCH_ADDR_W-1:0] fetch_pc;
  logic                     fetch_req;
  logic                     flush;
  logic                     hit;
  logic [31:0]              inst;
  logic                     rd_req;
  logic [`FETCH_ADDR_W-1:0] rd_addr;
  logic                     rd_done;
  logic [31:0]              rd_data;

  fetch_ctrl fetch_ctrl_i (
    .clk           (clk),
    .rst           (rst),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .ready_i       (ready_i),
    .hit_i         (hit),
    .inst_i        (inst),
    .fetch_pc_o    (fetch_pc),
    .fetch_req_o   (fetch_req),
    .flush_o       (flush),
    .valid_o       (valid_o),
    .inst_o        (inst_o),
    .pc_o          (pc_o)
  );

  l1i_cache l1i_cache_i (
    .clk         (clk),
    .rst         (rst),
    .fetch_req_i (fetch_req),
    .fetch_pc_i  (fetch_pc),
    .flush_i     (flush),
    .hit_o       (hit),
    .inst_o      (inst),
    .rd_req_o    (rd_req),
    .rd_addr_o   (rd_addr),
    .rd_done_i   (rd_done),
    .rd_data_i   (rd_data)
  );

  // one apb read per word of the line.
  apb_fetch_master apb_fetch_master_i (
    .clk       (clk),
    .rst       (rst),
    .rd_req_i  (rd_req),
    .rd_addr_i (rd_addr),
    .rd_done_o (rd_done),
    .rd_data_o (rd_data),
    .psel_o    (psel_o),
    .penable_o (penable_o),
    .paddr_o   (paddr_o),
    .pwrite_o  (pwrite_o),
    .prdata_i  (prdata_i),
    .pready_i  (pready_i)
  );

endmodule

`default_nettype wire

// File: fetch_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "fetch_settings.svh"

module fetch_ctrl
  import fetch_pkg::*;
(
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      redirect_i,
  input  wire [`FETCH_ADDR_W-1:0]  redirect_pc_i,
  input  wire                      ready_i,
  input  wire                      hit_i,
  input  wire [31:0]               inst_i,
  output logic [`FETCH_ADDR_W-1:0] fetch_pc_o,
  output logic                     fetch_req_o,
  output logic                     flush_o,
  output logic                     valid_o,
  output logic [31:0]              inst_o,
  output logic [`FETCH_ADDR_W-1:0] pc_o
);

  ifu_state_e               state_q;
  logic [`FETCH_ADDR_W-1:0] pc_q;
  opcode_e                  opcode;
  logic                     stop_seq;
  logic                     xfer;

  assign opcode = opcode_e'(inst_i[6:0]);

  // control transfer or load, back end supplies the next pc.
  assign stop_seq = opcode inside {OP_JAL, OP_JALR, OP_BRANCH, OP_SYSTEM, OP_LOAD};

  assign fetch_pc_o  = pc_q;
  assign fetch_req_o = (state_q == FETCH_RUN);

  assign valid_o = hit_i && (state_q == FETCH_RUN);
  assign inst_o  = inst_i;
  assign pc_o    = pc_q;

  assign xfer    = valid_o && ready_i;
  assign flush_o = xfer && (inst_i == `INST_FENCE_I);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= FETCH_RUN;
      pc_q    <= `FETCH_PC_INIT;
    end else begin
      case (state_q)
        FETCH_RUN: begin
          if (xfer) begin
            if (stop_seq) begin
              state_q <= FETCH_WAIT_REDIRECT;
            end else begin
              pc_q <= pc_q + `FETCH_ADDR_W'(4); // fence.i lands here too.
            end
          end
        end
        FETCH_WAIT_REDIRECT: begin
          if (redirect_i) begin
            pc_q    <= {redirect_pc_i[`FETCH_ADDR_W-1:2], 2'b00};
            state_q <= FETCH_RUN;
          end
        end
        default: begin
          state_q <= FETCH_RUN;
        end
      endcase
    end
  end

  // holds only while the cache leaves the hit line alone.
  out_hold: assert property (
    @(posedge clk) disable iff (rst)
    valid_o && !ready_i |=> valid_o && $stable(inst_o) && $stable(pc_o)
  ) else $error("fetch output changed under back-pressure.");

endmodule

`default_nettype wire

// File: apb_fetch_master.sv
`timescale 1ns/100ps
`default_nettype none
`include "fetch_settings.svh"

module apb_fetch_master
  import fetch_pkg::*;
(
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      rd_req_i,
  input  wire [`FETCH_ADDR_W-1:0]  rd_addr_i,
  output logic                     rd_done_o,
  output logic [31:0]              rd_data_o,
  output logic                     psel_o,
  output logic                     penable_o,
  output logic [`FETCH_ADDR_W-1:0] paddr_o,
  output logic                     pwrite_o,
  input  wire [31:0]               prdata_i,
  input  wire                      pready_i
);

  apb_state_e  state_q;
  logic        done_q;
  logic [31:0] data_q;
  logic        start;
  logic        finish;

  // rd_req is still up in the done cycle.
  assign start  = (state_q == APB_IDLE) && rd_req_i && !done_q;
  assign finish = (state_q == APB_ACCESS) && pready_i;

  assign psel_o    = (state_q != APB_IDLE);
  assign penable_o = (state_q == APB_ACCESS);
  assign paddr_o   = rd_addr_i; // cache holds it until done.
  assign pwrite_o  = 1'b0; // read only.
  assign rd_done_o = done_q;
  assign rd_data_o = data_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= APB_IDLE;
      done_q  <= 1'b0;
    end else begin
      done_q <= finish;
      case (state_q)
        APB_IDLE: begin
          if (start) begin
            state_q <= APB_SETUP;
          end
        end
        APB_SETUP: begin
          state_q <= APB_ACCESS; // setup is one cycle.
        end
        APB_ACCESS: begin
          if (pready_i) begin
            state_q <= APB_IDLE;
          end
        end
        default: begin
          state_q <= APB_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (finish) begin
      data_q <= prdata_i;
    end
  end

  // the cache must not move rd_addr while the transfer is open.
  paddr_stable: assert property (
    @(posedge clk) disable iff (rst)
    psel_o && !(penable_o && pready_i) |=> psel_o && $stable(paddr_o)
  ) else $error("paddr changed inside an apb transfer.");

endmodule

`default_nettype wire

// File: l1i_cache.sv
`timescale 1ns/100ps
`default_nettype none
`include "fetch_settings.svh"

module l1i_cache
  import fetch_pkg::*;
(
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      fetch_req_i,
  input  wire [`FETCH_ADDR_W-1:0]  fetch_pc_i,
  input  wire                      flush_i,
  output logic                     hit_o,
  output logic [31:0]              inst_o,
  output logic                     rd_req_o,
  output logic [`FETCH_ADDR_W-1:0] rd_addr_o,
  input  wire                      rd_done_i,
  input  wire [31:0]               rd_data_i
);

  localparam int TAG_W = `FETCH_ADDR_W - `L1I_IDX_W - `L1I_OFS_W - 2;

  logic [31:0]          data_q [`L1I_SETS][`L1I_LINE_WORDS];
  logic [TAG_W-1:0]     tag_q  [`L1I_SETS];
  logic [`L1I_SETS-1:0] valid_q;

  logic [TAG_W-1:0]      pc_tag;
  logic [`L1I_IDX_W-1:0] pc_idx;
  logic [`L1I_OFS_W-1:0] pc_ofs;

  fill_state_e           fill_q;
  logic [TAG_W-1:0]      fill_tag_q;
  logic [`L1I_IDX_W-1:0] fill_idx_q;
  logic [`L1I_OFS_W-1:0] fill_ofs;
  logic                  fill_start;
  logic                  fill_last;

  // pc split: tag | index | word | byte.
  assign pc_tag = fetch_pc_i[`FETCH_ADDR_W-1 -: TAG_W];
  assign pc_idx = fetch_pc_i[`L1I_OFS_W+2 +: `L1I_IDX_W];
  assign pc_ofs = fetch_pc_i[2 +: `L1I_OFS_W];

  assign hit_o  = valid_q[pc_idx] && (tag_q[pc_idx] == pc_tag);
  assign inst_o = data_q[pc_idx][pc_ofs];

  assign fill_start = (fill_q == FILL_IDLE) && fetch_req_i && !hit_o;
  assign fill_last  = (fill_q == FILL_WORD1) && rd_done_i;

  always_comb begin
    fill_ofs    = '0;
    fill_ofs[0] = (fill_q == FILL_WORD1); // odd word second.
  end

  assign rd_req_o  = (fill_q != FILL_IDLE);
  assign rd_addr_o = {fill_tag_q, fill_idx_q, fill_ofs, 2'b00};

  always_ff @(posedge clk) begin
    if (rst) begin
      fill_q  <= FILL_IDLE;
      valid_q <= '0;
    end else begin
      case (fill_q)
        FILL_IDLE: begin
          if (flush_i) begin
            valid_q <= '0; // fence.i drops every line.
          end else if (fill_start) begin
            valid_q[pc_idx] <= 1'b0;
            fill_q          <= FILL_WORD0;
          end
        end
        FILL_WORD0: begin
          if (rd_done_i) begin
            fill_q <= FILL_WORD1;
          end
        end
        FILL_WORD1: begin
          if (rd_done_i) begin
            valid_q[fill_idx_q] <= 1'b1;
            fill_q              <= FILL_IDLE;
          end
        end
        default: begin
          fill_q <= FILL_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fill_start) begin
      fill_tag_q <= pc_tag;
      fill_idx_q <= pc_idx;
    end
    if (rd_done_i && rd_req_o) begin
      data_q[fill_idx_q][fill_ofs] <= rd_data_i;
    end
    if (fill_last) begin
      tag_q[fill_idx_q] <= fill_tag_q;
    end
  end

  // pc is held by fetch_ctrl during a fill, so its line never hits meanwhile.
  hit_during_fill: assert property (
    @(posedge clk) disable iff (rst)
    !(hit_o && rd_req_o)
  ) else $error("l1i hit while a line fill is pending.");

endmodule

`default_nettype wire

// File: fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // opcodes that stop sequential fetch.
  typedef enum logic [6:0] {
    OP_LOAD   = 7'b000_0011,
    OP_BRANCH = 7'b110_0011,
    OP_JALR   = 7'b110_0111,
    OP_JAL    = 7'b110_1111,
    OP_SYSTEM = 7'b111_0011
  } opcode_e;

  typedef enum logic {
    FETCH_RUN,
    FETCH_WAIT_REDIRECT
  } ifu_state_e;

  // line fill, even word first.
  typedef enum logic [1:0] {
    FILL_IDLE,
    FILL_WORD0,
    FILL_WORD1
  } fill_state_e;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

endpackage

`default_nettype wire

// File: fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// pc and apb address width.
`define FETCH_ADDR_W 32

// first fetch address after reset.
`define FETCH_PC_INIT 32'h8000_0000

// direct-mapped l1i geometry.
`define L1I_SETS 4
`define L1I_LINE_WORDS 2

// index and word offset inside the pc.
`define L1I_IDX_W ($clog2(`L1I_SETS))
`define L1I_OFS_W ($clog2(`L1I_LINE_WORDS))

// fence.i, funct3 001 on the misc-mem opcode.
`define INST_FENCE_I 32'h0000_100f

`endif
